// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module video_scanline_tb \
	-f video_scanline_top.f \
	-o video_scanline_sim

# Keep running past assertion errors so the testbench reports them itself
output=$(./obj_dir/video_scanline_sim +verilator+error+limit+1000 2>&1) || true
echo "$output"

grep -q "Result: PASSED" <<< "$output"

// ==== testbench/video_scanline_assertions.sv ====
`timescale 1ns/10ps

module video_scanline_assertions (
	input logic                                CLK_VIDEO,
	input logic                                status,
	input logic [video_fx_pkg::color_bits-1:0] r_in,
	input logic [video_fx_pkg::color_bits-1:0] g_in,
	input logic [video_fx_pkg::color_bits-1:0] b_in,
	input logic                                hsync_n,
	input logic                                vsync_n,
	input logic                                hblank,
	input logic                                vblank,
	input logic [video_fx_pkg::sl_bits-1:0]    scanlines,
	input logic [video_fx_pkg::color_bits-1:0] VGA_R,
	input logic [video_fx_pkg::color_bits-1:0] VGA_G,
	input logic [video_fx_pkg::color_bits-1:0] VGA_B,
	input logic                                VGA_HS,
	input logic                                VGA_VS,
	input logic                                VGA_DE,
	input logic [video_fx_pkg::sl_bits-1:0]    VGA_SL,
	input logic                                CE_PIXEL
);
	import video_timing_pkg::*;
	import video_fx_pkg::*;

	// Failed assertions so far, watched by the testbench
	int unsigned err_count = 0;

	logic [pix_div_bits-1:0] div;
	logic                    ce;
	// Reference sync state, as the rules give it
	logic                    m_hs;
	logic                    m_vs;
	logic                    m_odd;
	logic [sl_bits-1:0]      m_sl;
	logic                    vs_rise;
	// Expected values, first at the sampling enable, then at the pins
	logic [color_bits-1:0]   pend_r, pend_g, pend_b;
	logic [color_bits-1:0]   exp_r, exp_g, exp_b;
	logic                    pend_de;
	logic                    exp_de;
	logic                    exp_hs;
	logic                    exp_vs;

	// Odd line value for a level code, shifts truncate
	function automatic logic [color_bits-1:0] shade(input logic [color_bits-1:0] pix,
			input logic blank, input logic odd, input logic [sl_bits-1:0] lvl);
		logic [color_bits-1:0] q;
		logic [color_bits-1:0] h;
		q = pix >> 2;
		h = pix >> 1;
		if (blank)
			return '0;
		if (!odd)
			return pix;
		case (lvl)
			2'd1:    return pix - q;
			2'd2:    return h;
			2'd3:    return q;
			default: return pix;
		endcase
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	assign ce      = (div == pix_div_max);
	// Frame starts when VS first goes high inside an HS pulse
	assign vs_rise = m_hs & ~hsync_n & ~vsync_n & ~m_vs;

	always_ff @(posedge CLK_VIDEO or posedge status) begin
		if (status) begin
			div     <= '0;
			m_hs    <= 1'b0;
			m_vs    <= 1'b0;
			m_odd   <= 1'b0;
			m_sl    <= '0;
			pend_r  <= '0;
			pend_g  <= '0;
			pend_b  <= '0;
			exp_r   <= '0;
			exp_g   <= '0;
			exp_b   <= '0;
			pend_de <= 1'b0;
			exp_de  <= 1'b0;
			exp_hs  <= 1'b0;
			exp_vs  <= 1'b0;
		end else begin
			div <= ce ? '0 : div + 1'b1;
			if (ce) begin
				m_hs <= ~hsync_n;
				if (m_hs & ~hsync_n)
					m_vs <= ~vsync_n;
				if (vs_rise) begin
					m_odd <= 1'b0;
					m_sl  <= scanlines;
				end else if (~hsync_n & ~m_hs) begin
					m_odd <= ~m_odd;
				end
				// Parity and level as they stand at the sample
				pend_r  <= shade(r_in, hblank | vblank, m_odd, m_sl);
				pend_g  <= shade(g_in, hblank | vblank, m_odd, m_sl);
				pend_b  <= shade(b_in, hblank | vblank, m_odd, m_sl);
				pend_de <= ~(hblank | vblank);
				exp_r   <= pend_r;
				exp_g   <= pend_g;
				exp_b   <= pend_b;
				exp_de  <= pend_de;
				exp_hs  <= m_hs;
				exp_vs  <= m_vs;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Assertions
	//////////////////////////////////////////////////////////////////////

	a_reset_quiet: assert property (@(posedge CLK_VIDEO)
		status |-> (!CE_PIXEL && !VGA_HS && !VGA_VS && !VGA_DE && VGA_SL == '0
			&& VGA_R == '0 && VGA_G == '0 && VGA_B == '0))
		else begin
			err_count++;
			$error("[FAIL] %0t: outputs not quiet during reset", $time);
		end

	// One enable, then seven idle clocks
	a_ce_period: assert property (@(posedge CLK_VIDEO) disable iff (status)
		CE_PIXEL == ce)
		else begin
			err_count++;
			$error("[FAIL] %0t: CE_PIXEL %0b, expected %0b", $time, CE_PIXEL, ce);
		end

	a_de: assert property (@(posedge CLK_VIDEO) disable iff (status) VGA_DE == exp_de)
		else begin
			err_count++;
			$error("[FAIL] %0t: VGA_DE %0b, expected %0b", $time, VGA_DE, exp_de);
		end

	a_blank_black: assert property (@(posedge CLK_VIDEO) disable iff (status)
		!VGA_DE |-> (VGA_R == '0 && VGA_G == '0 && VGA_B == '0))
		else begin
			err_count++;
			$error("[FAIL] %0t: colour not black while blanked", $time);
		end

	a_colour: assert property (@(posedge CLK_VIDEO) disable iff (status)
		VGA_R == exp_r && VGA_G == exp_g && VGA_B == exp_b)
		else begin
			err_count++;
			$error("[FAIL] %0t: RGB %h %h %h, expected %h %h %h", $time,
				VGA_R, VGA_G, VGA_B, exp_r, exp_g, exp_b);
		end

	a_hs: assert property (@(posedge CLK_VIDEO) disable iff (status) VGA_HS == exp_hs)
		else begin
			err_count++;
			$error("[FAIL] %0t: VGA_HS %0b, expected %0b", $time, VGA_HS, exp_hs);
		end

	a_vs: assert property (@(posedge CLK_VIDEO) disable iff (status) VGA_VS == exp_vs)
		else begin
			err_count++;
			$error("[FAIL] %0t: VGA_VS %0b, expected %0b", $time, VGA_VS, exp_vs);
		end

	// VS moves only inside HS
	a_vs_in_hs: assert property (@(posedge CLK_VIDEO) disable iff (status)
		$changed(VGA_VS) |-> VGA_HS)
		else begin
			err_count++;
			$error("[FAIL] %0t: VGA_VS changed outside VGA_HS", $time);
		end

	a_sl: assert property (@(posedge CLK_VIDEO) disable iff (status) VGA_SL == m_sl)
		else begin
			err_count++;
			$error("[FAIL] %0t: VGA_SL %0d, expected %0d", $time, VGA_SL, m_sl);
		end

endmodule

bind video_scanline_top video_scanline_assertions chk_i (
	.CLK_VIDEO (CLK_VIDEO),
	.status    (status),
	.r_in      (r_in),
	.g_in      (g_in),
	.b_in      (b_in),
	.hsync_n   (hsync_n),
	.vsync_n   (vsync_n),
	.hblank    (hblank),
	.vblank    (vblank),
	.scanlines (scanlines),
	.VGA_R     (VGA_R),
	.VGA_G     (VGA_G),
	.VGA_B     (VGA_B),
	.VGA_HS    (VGA_HS),
	.VGA_VS    (VGA_VS),
	.VGA_DE    (VGA_DE),
	.VGA_SL    (VGA_SL),
	.CE_PIXEL  (CE_PIXEL)
);

// ==== testbench/video_scanline_tb.sv ====
`timescale 1ns/10ps

module video_scanline_tb;
	import video_fx_pkg::*;

	logic                  CLK_VIDEO;
	logic                  status;
	logic [color_bits-1:0] r_in, g_in, b_in;
	logic                  hsync_n, vsync_n;
	logic                  hblank, vblank;
	logic [sl_bits-1:0]    scanlines;
	logic [color_bits-1:0] VGA_R, VGA_G, VGA_B;
	logic                  VGA_HS, VGA_VS, VGA_DE;
	logic [sl_bits-1:0]    VGA_SL;
	logic                  CE_PIXEL;

	logic [31:0]           rnd_state;

	video_scanline_top video_scanline_top_i (.*);

	//////////////////////////////////////////////////////////////////////
	// Clock, random source and helpers
	//////////////////////////////////////////////////////////////////////

	initial begin
		CLK_VIDEO = 1'b0;
		forever #5 CLK_VIDEO = ~CLK_VIDEO;
	end

	// 32 bit xorshift step
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Returns on the falling edge right after a sampling edge
	task automatic next_pixel();
		int n;
		n = 0;
		forever begin
			@(negedge CLK_VIDEO);
			if (CE_PIXEL)
				break;
			n++;
			if (n > 20) begin
				$display("Result: FAILED");
				$fatal(1, "Timeout while waiting for CE_PIXEL");
			end
		end
		@(negedge CLK_VIDEO);
	endtask

	// First assertion failure ends the run
	always @(negedge CLK_VIDEO) begin
		if (video_scanline_top_i.chk_i.err_count != 0) begin
			$display("Result: FAILED");
			$fatal(1, "Assertion failed in the checker");
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////

	initial begin
		status    = 1'b1;
		r_in      = '0;
		g_in      = '0;
		b_in      = '0;
		hsync_n   = 1'b1;
		vsync_n   = 1'b1;
		hblank    = 1'b0;
		vblank    = 1'b0;
		scanlines = '0;
		rnd_state = 32'h90e3f6c2;

		repeat (16) @(posedge CLK_VIDEO);
		@(negedge CLK_VIDEO);
		status = 1'b0;

		// Four frames of 12 lines, 40 pixels per line
		for (int f = 0; f < 4; f++) begin
			for (int l = 0; l < 12; l++) begin
				for (int p = 0; p < 40; p++) begin
					// This frame's level during vsync
					// Next frame's level shows up early and must wait for its VS rise
					scanlines = (l < 2) ? f[1:0] : f[1:0] + 2'd1;
					hsync_n   = (p >= 4);
					vsync_n   = (l >= 2);
					vblank    = (l < 3);
					rnd_state = xorshift32(rnd_state);
					r_in      = rnd_state[7:0];
					g_in      = rnd_state[15:8];
					b_in      = rnd_state[23:16];
					// Mostly the fixed border, now and then a random gap
					hblank    = (p < 8) || (rnd_state[31:28] == 4'd0);
					next_pixel();
				end
			end
		end

		// Let the last pixels reach the pins
		hblank = 1'b1;
		repeat (4) next_pixel();

		if (video_scanline_top_i.chk_i.err_count == 0) begin
			$display("Result: PASSED");
			$finish;
		end else begin
			$display("Result: FAILED");
			$fatal(1, "Checker reported errors");
		end
	end

endmodule

// ==== verilog/scanline_channel.sv ====
`timescale 1ns/10ps

module scanline_channel (
	input  logic                                CLK_VIDEO,
	input  logic                                status,
	video_stream_if.channel                     vid,
	input  logic [video_fx_pkg::color_bits-1:0] pix_in,
	output logic [video_fx_pkg::color_bits-1:0] pix_out
);
	import video_fx_pkg::*;

	logic [color_bits-1:0] dim;
	logic [color_bits-1:0] pix_nxt;

	// Darkened value for odd lines, shifts drop the low bits
	always_comb begin
		case (vid.sl_level)
			sl_25:   dim = pix_in - (pix_in >> 2);
			sl_50:   dim = pix_in >> 1;
			sl_75:   dim = pix_in >> 2;
			default: dim = pix_in;
		endcase
	end

	// Blank forces black, even lines pass untouched
	always_comb begin
		if (vid.blank) begin
			pix_nxt = '0;
		end else if (vid.odd_line) begin
			pix_nxt = dim;
		end else begin
			pix_nxt = pix_in;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Channel register, one per pixel enable
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_VIDEO or posedge status) begin
		if (status) begin
			pix_out <= '0;
		end else if (vid.ce_pix) begin
			pix_out <= pix_nxt;
		end
	end

	// Sample lines up with the shaped syncs of the same enable

endmodule

// ==== verilog/video_fx_pkg.sv ====
package video_fx_pkg;

	//////////////////////////////////////////////////////////////////////
	// Colour path
	//////////////////////////////////////////////////////////////////////

	// Bits per colour component
	localparam int color_bits = 8;

	// One channel each for R, G and B
	localparam int num_channels = 3;

	//////////////////////////////////////////////////////////////////////
	// Scanline darkening
	//////////////////////////////////////////////////////////////////////

	// Width of the scanline level code
	localparam int sl_bits = 2;

	// Level codes, as the OSD hands them over
	localparam logic [sl_bits-1:0] sl_none = 2'd0;
	// Odd line keeps three quarters
	localparam logic [sl_bits-1:0] sl_25   = 2'd1;
	// Odd line keeps half
	localparam logic [sl_bits-1:0] sl_50   = 2'd2;
	// Odd line keeps one quarter
	localparam logic [sl_bits-1:0] sl_75   = 2'd3;

endpackage

// ==== verilog/video_out_stage.sv ====
`timescale 1ns/10ps

module video_out_stage (
	input  logic                                CLK_VIDEO,
	input  logic                                status,
	video_stream_if.sink                        vid,
	input  logic [video_fx_pkg::color_bits-1:0] chan_pix [video_fx_pkg::num_channels],
	output logic [video_fx_pkg::color_bits-1:0] VGA_R,
	output logic [video_fx_pkg::color_bits-1:0] VGA_G,
	output logic [video_fx_pkg::color_bits-1:0] VGA_B,
	output logic                                VGA_HS,
	output logic                                VGA_VS,
	output logic                                VGA_DE,
	output logic [video_fx_pkg::sl_bits-1:0]    VGA_SL,
	output logic                                CE_PIXEL
);
	import video_timing_pkg::*;

	// Raw blank enters at the sampling enable
	// Shifted out at the enable that drives the pins
	logic [pipe_ce_stages-1:0] blank_pipe;

	//////////////////////////////////////////////////////////////////////
	// Output registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_VIDEO or posedge status) begin
		if (status) begin
			blank_pipe <= '1;
			VGA_HS     <= 1'b0;
			VGA_VS     <= 1'b0;
			VGA_R      <= '0;
			VGA_G      <= '0;
			VGA_B      <= '0;
		end else if (vid.ce_pix) begin
			blank_pipe <= {blank_pipe[pipe_ce_stages-2:0], vid.blank};
			// Shaper already spent one enable on the syncs
			VGA_HS     <= vid.hs;
			VGA_VS     <= vid.vs;
			// Channel order is R, G, B
			VGA_R      <= chan_pix[0];
			VGA_G      <= chan_pix[1];
			VGA_B      <= chan_pix[2];
		end
	end

	// Pipe is all ones in reset, so DE stays low
	assign VGA_DE = ~blank_pipe[pipe_ce_stages-1];

	// Scaler reads the level and the enable directly
	assign VGA_SL   = vid.sl_level;
	assign CE_PIXEL = vid.ce_pix;

endmodule

// ==== verilog/video_scanline_top.sv ====
`timescale 1ns/10ps

module video_scanline_top (
	input  logic                                CLK_VIDEO,
	input  logic                                status,
	input  logic [video_fx_pkg::color_bits-1:0] r_in,
	input  logic [video_fx_pkg::color_bits-1:0] g_in,
	input  logic [video_fx_pkg::color_bits-1:0] b_in,
	input  logic                                hsync_n,
	input  logic                                vsync_n,
	input  logic                                hblank,
	input  logic                                vblank,
	input  logic [video_fx_pkg::sl_bits-1:0]    scanlines,
	output logic [video_fx_pkg::color_bits-1:0] VGA_R,
	output logic [video_fx_pkg::color_bits-1:0] VGA_G,
	output logic [video_fx_pkg::color_bits-1:0] VGA_B,
	output logic                                VGA_HS,
	output logic                                VGA_VS,
	output logic                                VGA_DE,
	output logic [video_fx_pkg::sl_bits-1:0]    VGA_SL,
	output logic                                CE_PIXEL
);
	import video_fx_pkg::*;

	// Core pixels in R, G, B order
	wire [color_bits-1:0] pix_in   [num_channels];
	// Registered channel values
	wire [color_bits-1:0] chan_pix [num_channels];

	video_stream_if vid ();

	assign pix_in[0] = r_in;
	assign pix_in[1] = g_in;
	assign pix_in[2] = b_in;

	//////////////////////////////////////////////////////////////////////
	// Timing, colour channels and output
	//////////////////////////////////////////////////////////////////////

	video_sync_shaper shaper_i (
		.CLK_VIDEO (CLK_VIDEO),
		.status    (status),
		.hsync_n   (hsync_n),
		.vsync_n   (vsync_n),
		.hblank    (hblank),
		.vblank    (vblank),
		.scanlines (scanlines),
		.vid       (vid)
	);

	// Same block for every colour
	for (genvar i = 0; i < num_channels; i++) begin : g_chan
		scanline_channel chan_i (
			.CLK_VIDEO (CLK_VIDEO),
			.status    (status),
			.vid       (vid),
			.pix_in    (pix_in[i]),
			.pix_out   (chan_pix[i])
		);
	end

	video_out_stage out_i (
		.CLK_VIDEO (CLK_VIDEO),
		.status    (status),
		.vid       (vid),
		.chan_pix  (chan_pix),
		.VGA_R     (VGA_R),
		.VGA_G     (VGA_G),
		.VGA_B     (VGA_B),
		.VGA_HS    (VGA_HS),
		.VGA_VS    (VGA_VS),
		.VGA_DE    (VGA_DE),
		.VGA_SL    (VGA_SL),
		.CE_PIXEL  (CE_PIXEL)
	);

endmodule

// ==== verilog/video_stream_if.sv ====
`timescale 1ns/10ps

// Shaped raster timing shared by the shaper, the channels and the out stage
interface video_stream_if;

	// One CLK_VIDEO wide strobe, once per pixel
	logic ce_pix;
	// Positive syncs
	logic hs;
	logic vs;
	// Combined horizontal and vertical blanking
	logic blank;
	// High on odd raster lines of the frame
	logic odd_line;
	// Scanline level, frozen for the frame
	logic [video_fx_pkg::sl_bits-1:0] sl_level;

	// Shaper drives everything
	modport source (
		output ce_pix, hs, vs, blank, odd_line, sl_level
	);

	// Colour channels only need the pixel qualifiers
	modport channel (
		input ce_pix, blank, odd_line, sl_level
	);

	// Out stage needs the syncs and blank to rebuild DE
	modport sink (
		input ce_pix, hs, vs, blank, sl_level
	);

endinterface

// ==== verilog/video_sync_shaper.sv ====
`timescale 1ns/10ps

module video_sync_shaper (
	input  logic                             CLK_VIDEO,
	input  logic                             status,
	input  logic                             hsync_n,
	input  logic                             vsync_n,
	input  logic                             hblank,
	input  logic                             vblank,
	input  logic [video_fx_pkg::sl_bits-1:0] scanlines,
	video_stream_if.source                   vid
);
	import video_timing_pkg::*;
	import video_fx_pkg::*;

	logic [pix_div_bits-1:0] div;
	logic                    hs_r;
	logic                    vs_r;
	logic                    odd_r;
	logic [sl_bits-1:0]      sl_r;
	logic                    hs_rise;
	logic                    vs_load;
	logic                    vs_rise;

	//////////////////////////////////////////////////////////////////////
	// Pixel enable, CLK_VIDEO divided by eight
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_VIDEO or posedge status) begin
		if (status) begin
			div <= '0;
		end else if (div == pix_div_max) begin
			div <= '0;
		end else begin
			div <= div + 1'b1;
		end
	end

	// Counter sits at zero in reset, so no enable comes out
	assign vid.ce_pix = (div == pix_div_max);

	//////////////////////////////////////////////////////////////////////
	// Sync shaping, parity and level latch
	//////////////////////////////////////////////////////////////////////

	// HS about to go high on this enable
	assign hs_rise = ~hsync_n & ~hs_r;
	// VS may only move inside an active HS pulse
	assign vs_load = hs_r & ~hsync_n;
	// Start of a new frame
	assign vs_rise = vs_load & ~vsync_n & ~vs_r;

	always_ff @(posedge CLK_VIDEO or posedge status) begin
		if (status) begin
			hs_r  <= 1'b0;
			vs_r  <= 1'b0;
			odd_r <= 1'b0;
			sl_r  <= sl_none;
		end else if (vid.ce_pix) begin
			hs_r <= ~hsync_n;
			if (vs_load) begin
				vs_r <= ~vsync_n;
			end
			// Frame start wins, line 0 is even
			if (vs_rise) begin
				odd_r <= 1'b0;
			end else if (hs_rise) begin
				odd_r <= ~odd_r;
			end
			// Level only changes between frames
			if (vs_rise) begin
				sl_r <= scanlines;
			end
		end
	end

	assign vid.hs       = hs_r;
	assign vid.vs       = vs_r;
	assign vid.blank    = hblank | vblank;
	assign vid.odd_line = odd_r;
	assign vid.sl_level = sl_r;

endmodule

// ==== verilog/video_timing_pkg.sv ====
package video_timing_pkg;

	//////////////////////////////////////////////////////////////////////
	// Pixel clock divider
	//////////////////////////////////////////////////////////////////////

	// Width of the enable divider counter
	localparam int pix_div_bits = 3;

	// Counter value that fires the pixel enable
	// One enable every eight CLK_VIDEO cycles
	localparam logic [pix_div_bits-1:0] pix_div_max = 3'd7;

	//////////////////////////////////////////////////////////////////////
	// Pipeline timing
	//////////////////////////////////////////////////////////////////////

	// Pixel enables from input sample to the VGA outputs
	// First enable samples the core, second one drives the pins
	localparam int pipe_ce_stages = 2;

	// Sync polarity on the core side is active low
	// VGA side pulses are positive, see the sync shaper

endpackage

// ==== video_scanline_top.f ====
verilog/video_timing_pkg.sv
verilog/video_fx_pkg.sv
verilog/video_stream_if.sv
verilog/video_sync_shaper.sv
verilog/scanline_channel.sv
verilog/video_out_stage.sv
verilog/video_scanline_top.sv
testbench/video_scanline_assertions.sv
testbench/video_scanline_tb.sv
